// ==== project.f ====
verilog/soc_pkg.sv
verilog/reset_sequencer.sv
verilog/boot_control.sv
verilog/bus_interconnect.sv
verilog/sram_bank.sv
verilog/uart_tx.sv
verilog/soc_top.sv
tests/soc_checker.sv
tests/soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module soc_tb \
   -f project.f -o soc_sim > sim.log 2>&1 \
   && ./obj_dir/soc_sim >> sim.log 2>&1 \
   || { cat sim.log; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
exit 0

// ==== tests/soc_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_checker #(
   parameter int UART_DIV_RESET = 16,
   parameter int SYS_RST_EDGES  = 16
) (
   input  wire        clk,
   input  wire        reset,
   input  wire        m_valid,
   input  wire [31:0] m_addr,
   input  wire [31:0] m_wdata,
   input  wire [3:0]  m_wstrb,
   input  wire        m_ready,
   input  wire [31:0] m_rdata,
   input  wire        core_resetn,
   input  wire        sys_ready,
   input  wire        mem_sel,
   input  wire        ser_tx,
   // Expectation that travels with the current transfer
   input  wire [3:0]  exp_kind,
   input  wire [31:0] exp_value,
   output int         error_count,
   output int         check_count,
   output logic       frame_busy
);

   localparam int          SOFT_LOW_CYCLES = 5;
   localparam logic [31:0] SOFT_ADDR       = 32'h6FFF_FFFC;
   localparam logic [3:0]  KIND_READ       = 4'd2;
   localparam logic [3:0]  KIND_SERIAL     = 4'd3;

   // Reference memories keyed by word index
   logic [31:0] boot_model [int];
   logic [31:0] main_model [int];

   int          edges;
   int          soft_phase;
   int          frame_cyc;
   int          bit_idx;
   bit          remapped;
   logic [15:0] div_model;
   logic [15:0] frame_div;
   logic [7:0]  frame_byte;
   logic        exp_bit;

   initial begin
      error_count = 0;
      check_count = 0;
      frame_busy  = 1'b0;
   end

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
      logic [31:0] res;
      res = old_word;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Memory and UART models updated on each accepted transfer
   //////////////////////////////////////////////////////////////////////

   task automatic take_transfer();
      logic [31:0] old_word;
      bit          to_main;
      int          idx;
      to_main = (m_addr[31:28] == 4'h1) || remapped;
      idx     = to_main ? int'(m_addr[11:2]) : int'(m_addr[9:2]);
      case (m_addr[31:28])
         4'h0, 4'h1: begin
            if (|m_wstrb) begin
               // Unwritten lanes stay unknown
               old_word = 32'hx;
               if (to_main && main_model.exists(idx)) old_word = main_model[idx];
               if (!to_main && boot_model.exists(idx)) old_word = boot_model[idx];
               if (to_main) main_model[idx] = merge_bytes(old_word, m_wdata, m_wstrb);
               else boot_model[idx] = merge_bytes(old_word, m_wdata, m_wstrb);
            end else begin
               old_word = 32'hx;
               if (to_main && main_model.exists(idx)) old_word = main_model[idx];
               if (!to_main && boot_model.exists(idx)) old_word = boot_model[idx];
               if (!$isunknown(old_word)) compare("m_rdata (model)", old_word, m_rdata);
            end
         end
         4'h2: begin
            if (|m_wstrb && m_addr[3:2] == 2'd0) begin
               if (frame_busy) begin
                  error_count++;
                  $display("UART data write was accepted while a frame was still sent");
               end
               frame_busy = 1'b1;
               frame_cyc  = 0;
               frame_div  = div_model;
               frame_byte = (exp_kind == KIND_SERIAL) ? exp_value[7:0] : m_wdata[7:0];
            end
            if (|m_wstrb && m_addr[3:2] == 2'd1) begin
               div_model = 16'(merge_bytes({16'd0, div_model}, m_wdata, m_wstrb & 4'b0011));
            end
         end
         4'h6: begin
            if (m_addr == SOFT_ADDR) begin
               soft_phase = 1;
               remapped   = 1'b1;
            end
         end
         default: ;
      endcase
      if (exp_kind == KIND_READ) compare("m_rdata", exp_value, m_rdata);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Per-edge checks on values sampled before the edge updates them
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (reset) begin
         edges      = 0;
         soft_phase = 0;
         remapped   = 1'b0;
         div_model  = 16'(UART_DIV_RESET);
         frame_busy = 1'b0;
         frame_cyc  = 0;
      end else begin
         // Power-on release after a fixed edge count
         compare("sys_ready", 32'(edges >= SYS_RST_EDGES), 32'(sys_ready));
         if (edges < SYS_RST_EDGES) begin
            compare("core_resetn", 32'd0, 32'(core_resetn));
            compare("m_ready", 32'd0, 32'(m_ready));
            edges++;
         end else if (soft_phase == 0) begin
            // Core released outside a soft reset pulse
            compare("core_resetn", 32'd1, 32'(core_resetn));
         end
         // Remap flag sets with the soft reset and then holds
         compare("mem_sel", 32'(remapped), 32'(mem_sel));
         // Soft reset gives one high edge and then the low pulse
         if (soft_phase > 0) begin
            compare("core_resetn",
                    32'(!(soft_phase >= 2 && soft_phase <= SOFT_LOW_CYCLES + 1)),
                    32'(core_resetn));
            soft_phase = (soft_phase == SOFT_LOW_CYCLES + 2) ? 0 : soft_phase + 1;
         end
         // Mid-bit sampling of the serial line
         if (frame_busy) begin
            frame_cyc++;
            if ((frame_cyc - 1) % int'(frame_div) == int'(frame_div) / 2) begin
               bit_idx = (frame_cyc - 1) / int'(frame_div);
               if (bit_idx == 0) exp_bit = 1'b0;
               else if (bit_idx == 9) exp_bit = 1'b1;
               else exp_bit = frame_byte[bit_idx-1];
               compare("ser_tx", 32'(exp_bit), 32'(ser_tx));
               if (bit_idx == 9) frame_busy = 1'b0;
            end
         end
         if (m_valid && m_ready) take_transfer();
      end
   end

endmodule

`default_nettype wire

// ==== tests/soc_stim.txt ====
// op_addr_wdata_strb_expect, op 1 write, 2 read and compare, 3 UART byte, 5 soft reset
// op 0 ends the list
1_00000040_11111111_F_00000000
1_10000040_AABBCCDD_F_00000000
2_00000040_00000000_0_11111111
2_10000040_00000000_0_AABBCCDD
1_10000010_11223344_F_00000000
1_10000010_0000AA00_2_00000000
2_10000010_00000000_0_1122AA44
1_10000010_55660000_C_00000000
2_10000010_00000000_0_5566AA44
1_00000004_CAFEF00D_F_00000000
1_00000004_00000099_1_00000000
2_00000004_00000000_0_CAFEF099
2_30000000_00000000_0_DEADBEEF
2_F0000100_00000000_0_DEADBEEF
2_60000000_00000000_0_00000000
2_20000004_00000000_0_00000008
1_20000004_00000006_3_00000000
2_20000004_00000000_0_00000006
3_20000000_00000055_1_00000055
2_20000008_00000000_0_00000001
3_20000000_000000A3_1_000000A3
3_20000000_0000003C_1_0000003C
5_6FFFFFFC_00000000_F_00000000
2_00000040_00000000_0_AABBCCDD
2_00000010_00000000_0_5566AA44
1_00000020_0BADF00D_F_00000000
2_10000020_00000000_0_0BADF00D
0_00000000_00000000_0_00000000

// ==== tests/soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_tb;

   localparam int RST_CNT_W  = 4;
   localparam int UART_DIV   = 8;
   localparam int CLK_PERIOD = 20;
   localparam int STIM_DEPTH = 64;
   localparam int XFER_LIMIT = 1000;
   // Longest single operation is a stalled UART write
   localparam int OP_CYCLES  = 2 * (10 * UART_DIV) + 8;

   logic        clk;
   logic        reset;
   logic        m_valid;
   logic [31:0] m_addr;
   logic [31:0] m_wdata;
   logic [3:0]  m_wstrb;
   logic [3:0]  exp_kind;
   logic [31:0] exp_value;
   wire         m_ready;
   wire  [31:0] m_rdata;
   wire         core_resetn;
   wire         sys_ready;
   wire         mem_sel;
   wire         ser_tx;
   wire         frame_busy;
   int          error_count;
   int          check_count;
   int          tb_errors;
   int          n_ops;
   int          limit_cycles;

   // Stim columns are op, address, write data, strobe and expected value
   logic [103:0] stim [0:STIM_DEPTH-1];

   soc_top #(
      .RST_CNT_W      (RST_CNT_W),
      .MEM_ADDR_W     (10),
      .BOOT_ADDR_W    (8),
      .UART_DIV_RESET (UART_DIV)
   ) DUT (
      .clk         (clk),
      .reset       (reset),
      .m_valid     (m_valid),
      .m_addr      (m_addr),
      .m_wdata     (m_wdata),
      .m_wstrb     (m_wstrb),
      .m_ready     (m_ready),
      .m_rdata     (m_rdata),
      .core_resetn (core_resetn),
      .sys_ready   (sys_ready),
      .mem_sel     (mem_sel),
      .ser_tx      (ser_tx)
   );

   soc_checker #(
      .UART_DIV_RESET (UART_DIV),
      .SYS_RST_EDGES  (2**RST_CNT_W)
   ) u_checker (
      .clk         (clk),
      .reset       (reset),
      .m_valid     (m_valid),
      .m_addr      (m_addr),
      .m_wdata     (m_wdata),
      .m_wstrb     (m_wstrb),
      .m_ready     (m_ready),
      .m_rdata     (m_rdata),
      .core_resetn (core_resetn),
      .sys_ready   (sys_ready),
      .mem_sel     (mem_sel),
      .ser_tx      (ser_tx),
      .exp_kind    (exp_kind),
      .exp_value   (exp_value),
      .error_count (error_count),
      .check_count (check_count),
      .frame_busy  (frame_busy)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // Lines up to the end marker or the end of the file
   function automatic int count_ops();
      int n;
      n = 0;
      while (n < STIM_DEPTH && !$isunknown(stim[n]) && stim[n][103:100] inside {[1:5]}) begin
         n++;
      end
      return n;
   endfunction

   task automatic wait_core_running();
      while (!core_resetn) @(posedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // One master transfer held until ready
   //////////////////////////////////////////////////////////////////////

   task automatic run_op(input logic [103:0] line);
      int waited;
      @(posedge clk);
      m_valid   <= 1'b1;
      m_addr    <= line[99:68];
      m_wdata   <= line[67:36];
      m_wstrb   <= line[35:32];
      exp_kind  <= line[103:100];
      exp_value <= line[31:0];
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (!m_ready && waited < XFER_LIMIT);
      if (!m_ready) begin
         tb_errors++;
         $display("Transfer to %h got no ready within %0d cycles", line[99:68], XFER_LIMIT);
      end
      m_valid  <= 1'b0;
      m_wstrb  <= 4'd0;
      exp_kind <= 4'd0;
      // Core stays idle through the soft reset pulse
      if (line[103:100] == 4'd5) begin
         @(posedge clk);
         @(posedge clk);
         wait_core_running();
      end
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      m_valid   = 1'b0;
      m_addr    = '0;
      m_wdata   = '0;
      m_wstrb   = '0;
      exp_kind  = '0;
      exp_value = '0;
      tb_errors = 0;
      $readmemh("tests/soc_stim.txt", stim);
      n_ops = count_ops();
      if (n_ops == 0) begin
         tb_errors++;
         $display("Stimulus file holds no operations");
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      wait_core_running();
      for (int i = 0; i < n_ops; i++) begin
         run_op(stim[i]);
      end
      // Let the last frame drain
      @(negedge clk);
      while (frame_busy) @(negedge clk);
      repeat (2) @(negedge clk);
      $display("Summary: %0d operations, %0d checks, %0d checker errors, %0d bus errors",
               n_ops, check_count, error_count, tb_errors);
      if (error_count + tb_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog allows the reset time plus the worst case per operation
   initial begin
      wait (n_ops > 0 || tb_errors > 0);
      limit_cycles = 5 + 2**RST_CNT_W + 8 + (n_ops + 1) * OP_CYCLES;
      #(limit_cycles * CLK_PERIOD);
      $display("Watchdog stopped the run after %0d cycles", limit_cycles);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/boot_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module boot_control (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       sys_ready,
   input  wire                       sys_valid,
   input  wire [soc_pkg::ADDR_W-1:0] sys_addr,
   output logic                      sys_ready_out,
   output logic                      mem_sel,
   output logic                      core_resetn
);
   import soc_pkg::*;

   // Bit 0 drives the core reset, zero slot in front delays it one cycle
   logic [SOFT_RESET_CYCLES:0] hold_sr;
   logic                       soft_hit;

   // Soft reset fires on the accepting edge only
   assign soft_hit = sys_valid & sys_ready_out & (sys_addr == SOFT_RESET_ADDR);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         sys_ready_out <= 1'b0;
         mem_sel       <= 1'b0;
         hold_sr       <= '0;
      end else if (!sys_ready) begin
         // Parked while power-on reset runs
         sys_ready_out <= 1'b0;
         mem_sel       <= 1'b0;
         hold_sr       <= '0;
      end else begin
         // One-cycle acknowledge, dropped again after the handshake
         sys_ready_out <= sys_valid & ~sys_ready_out;
         if (soft_hit) begin
            // Sticky remap to main RAM
            mem_sel <= 1'b1;
            hold_sr <= {{SOFT_RESET_CYCLES{1'b1}}, 1'b0};
         end else begin
            hold_sr <= {1'b0, hold_sr[SOFT_RESET_CYCLES:1]};
         end
      end
   end

   // Core stays down during power-on and the soft reset pulse
   assign core_resetn = sys_ready & ~hold_sr[0];

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // One cycle gap, then exactly SOFT_RESET_CYCLES low, then released
   soft_reset_pulse: assert property (
      @(posedge clk) disable iff (reset)
      soft_hit |=> core_resetn ##1 !core_resetn [*SOFT_RESET_CYCLES] ##1 core_resetn
   );

endmodule

`default_nettype wire

// ==== verilog/bus_interconnect.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_interconnect (
   input  wire                                           clk,
   input  wire                                           reset,
   input  wire                                           mem_sel,
   input  wire                                           m_valid,
   input  wire  [soc_pkg::ADDR_W-1:0]                    m_addr,
   input  wire  [soc_pkg::STRB_W-1:0]                    m_wstrb,
   output logic                                          m_ready,
   output logic [soc_pkg::DATA_W-1:0]                    m_rdata,
   output logic [soc_pkg::N_SLAVES-1:0]                  s_valid,
   input  wire  [soc_pkg::N_SLAVES-1:0]                  s_ready,
   input  wire  [soc_pkg::N_SLAVES*soc_pkg::DATA_W-1:0]  s_rdata,
   output logic                                          err_ready
);
   import soc_pkg::*;

   logic [SEL_W-1:0]    sel;
   logic [REGION_W-1:0] region;

   assign region = m_addr[REGION_HI -: REGION_W];

   //////////////////////////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (region)
         // Low window follows the remap flag
         REGION_LOW:  sel = mem_sel ? SLV_MAIN : SLV_BOOT;
         REGION_MAIN: sel = SLV_MAIN;
         REGION_UART: sel = SLV_UART;
         REGION_SYS:  sel = SLV_SYS;
         default:     sel = SLV_NONE;
      endcase
   end

   // Request goes to the selected slot only
   always_comb begin
      s_valid      = '0;
      s_valid[sel] = m_valid;
   end

   // Response path back from the same slot
   assign m_ready = s_ready[sel];
   assign m_rdata = (sel == SLV_NONE) ? BUS_ERR_WORD : s_rdata[sel*DATA_W +: DATA_W];

   //////////////////////////////////////////////////////////////////////
   // Error slave for unmapped regions
   //////////////////////////////////////////////////////////////////////

   // Single-cycle ack, same timing as the memories
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         err_ready <= 1'b0;
      end else begin
         err_ready <= s_valid[SLV_NONE] & ~err_ready;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Never two slaves addressed at once
   one_slave: assert property (
      @(posedge clk) disable iff (reset)
      $onehot0(s_valid)
   );

   // Decode relies on the master holding its request until ready
   master_hold: assert property (
      @(posedge clk) disable iff (reset)
      m_valid && !m_ready |=> m_valid && $stable(m_addr) && $stable(m_wstrb)
   );

endmodule

`default_nettype wire

// ==== verilog/reset_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
   parameter int RST_CNT_W = 10
) (
   input  wire  clk,
   input  wire  reset,
   output logic sys_ready
);

   // One extra bit, the top one flags the end of the count
   logic [RST_CNT_W:0] rst_cnt;

   // Saturating power-on counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rst_cnt <= '0;
      end else if (!rst_cnt[RST_CNT_W]) begin
         rst_cnt <= rst_cnt + 1'b1;
      end
   end

   // Top bit sets after 2**RST_CNT_W edges and then holds
   assign sys_ready = rst_cnt[RST_CNT_W];

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Once released, only the external reset may pull the system back
   sys_ready_holds: assert property (
      @(posedge clk) disable iff (reset)
      !$fell(sys_ready)
   );

endmodule

`default_nettype wire

// ==== verilog/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   //////////////////////////////////////////////////////////////////////
   // Native bus widths
   //////////////////////////////////////////////////////////////////////

   // Core memory port, word wide with byte strobes
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   //////////////////////////////////////////////////////////////////////
   // Slave slots behind the interconnect
   //////////////////////////////////////////////////////////////////////

   localparam int N_SLAVES = 5;
   localparam int SEL_W    = 3;

   // Slot index per slave
   localparam logic [SEL_W-1:0] SLV_BOOT = 3'd0;
   localparam logic [SEL_W-1:0] SLV_MAIN = 3'd1;
   localparam logic [SEL_W-1:0] SLV_UART = 3'd2;
   localparam logic [SEL_W-1:0] SLV_SYS  = 3'd3;
   // Catch-all for holes in the map
   localparam logic [SEL_W-1:0] SLV_NONE = 3'd4;

   //////////////////////////////////////////////////////////////////////
   // Address map
   //////////////////////////////////////////////////////////////////////

   // Region field is the top nibble of the address
   localparam int REGION_HI = 31;
   localparam int REGION_W  = 4;

   // Low window, boot memory until remap
   localparam logic [REGION_W-1:0] REGION_LOW  = 4'h0;
   localparam logic [REGION_W-1:0] REGION_MAIN = 4'h1;
   localparam logic [REGION_W-1:0] REGION_UART = 4'h2;
   localparam logic [REGION_W-1:0] REGION_SYS  = 4'h6;

   // Last word of the system control region
   localparam logic [ADDR_W-1:0] SOFT_RESET_ADDR = 32'h6FFF_FFFC;

   // Read value for unmapped space
   localparam logic [DATA_W-1:0] BUS_ERR_WORD = 32'hDEAD_BEEF;

   // Core held in reset this many cycles after a soft reset
   localparam int SOFT_RESET_CYCLES = 5;

   // UART registers, word offset from address bits 3:2
   localparam logic [1:0] UART_REG_DATA = 2'd0;
   localparam logic [1:0] UART_REG_DIV  = 2'd1;
   localparam logic [1:0] UART_REG_STAT = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/soc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
   parameter int RST_CNT_W      = 10,
   parameter int MEM_ADDR_W     = 10,
   parameter int BOOT_ADDR_W    = 8,
   parameter int UART_DIV_RESET = 16
) (
   input  wire                        clk,
   input  wire                        reset,
   // Core memory port
   input  wire                        m_valid,
   input  wire  [soc_pkg::ADDR_W-1:0] m_addr,
   input  wire  [soc_pkg::DATA_W-1:0] m_wdata,
   input  wire  [soc_pkg::STRB_W-1:0] m_wstrb,
   output wire                        m_ready,
   output wire  [soc_pkg::DATA_W-1:0] m_rdata,
   // System status
   output wire                        core_resetn,
   output wire                        sys_ready,
   output wire                        mem_sel,
   output wire                        ser_tx
);
   import soc_pkg::*;

   wire [N_SLAVES-1:0]        s_valid;
   wire [N_SLAVES-1:0]        s_ready;
   wire [N_SLAVES*DATA_W-1:0] s_rdata;

   // System control and unmapped slots carry no data
   assign s_rdata[SLV_SYS*DATA_W +: DATA_W]  = '0;
   assign s_rdata[SLV_NONE*DATA_W +: DATA_W] = '0;

   //////////////////////////////////////////////////////////////////////
   // Reset and boot
   //////////////////////////////////////////////////////////////////////

   reset_sequencer #(.RST_CNT_W(RST_CNT_W)) u_rst_seq (
      .clk       (clk),
      .reset     (reset),
      .sys_ready (sys_ready)
   );

   boot_control u_boot_ctrl (
      .clk           (clk),
      .reset         (reset),
      .sys_ready     (sys_ready),
      .sys_valid     (s_valid[SLV_SYS]),
      .sys_addr      (m_addr),
      .sys_ready_out (s_ready[SLV_SYS]),
      .mem_sel       (mem_sel),
      .core_resetn   (core_resetn)
   );

   //////////////////////////////////////////////////////////////////////
   // Interconnect and slaves
   //////////////////////////////////////////////////////////////////////

   bus_interconnect u_xbar (
      .clk       (clk),
      .reset     (reset),
      .mem_sel   (mem_sel),
      .m_valid   (m_valid),
      .m_addr    (m_addr),
      .m_wstrb   (m_wstrb),
      .m_ready   (m_ready),
      .m_rdata   (m_rdata),
      .s_valid   (s_valid),
      .s_ready   (s_ready),
      .s_rdata   (s_rdata),
      .err_ready (s_ready[SLV_NONE])
   );

   // Boot memory, low window before remap
   sram_bank #(.MEM_ADDR_W(BOOT_ADDR_W)) boot_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[SLV_BOOT]),
      .addr  (m_addr),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .ready (s_ready[SLV_BOOT]),
      .rdata (s_rdata[SLV_BOOT*DATA_W +: DATA_W])
   );

   sram_bank #(.MEM_ADDR_W(MEM_ADDR_W)) main_mem (
      .clk   (clk),
      .reset (reset),
      .valid (s_valid[SLV_MAIN]),
      .addr  (m_addr),
      .wdata (m_wdata),
      .wstrb (m_wstrb),
      .ready (s_ready[SLV_MAIN]),
      .rdata (s_rdata[SLV_MAIN*DATA_W +: DATA_W])
   );

   uart_tx #(.UART_DIV_RESET(UART_DIV_RESET)) u_uart (
      .clk    (clk),
      .reset  (reset),
      .valid  (s_valid[SLV_UART]),
      .addr   (m_addr),
      .wdata  (m_wdata),
      .wstrb  (m_wstrb),
      .ready  (s_ready[SLV_UART]),
      .rdata  (s_rdata[SLV_UART*DATA_W +: DATA_W]),
      .ser_tx (ser_tx)
   );

endmodule

`default_nettype wire

// ==== verilog/sram_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_bank #(
   parameter int MEM_ADDR_W = 10
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        valid,
   input  wire  [soc_pkg::ADDR_W-1:0] addr,
   input  wire  [soc_pkg::DATA_W-1:0] wdata,
   input  wire  [soc_pkg::STRB_W-1:0] wstrb,
   output logic                       ready,
   output logic [soc_pkg::DATA_W-1:0] rdata
);
   import soc_pkg::*;

   logic [DATA_W-1:0]     mem [0:(2**MEM_ADDR_W)-1];
   logic [MEM_ADDR_W-1:0] word_addr;
   logic                  access;

   // Word index, byte offset dropped
   assign word_addr = addr[MEM_ADDR_W+1:2];
   // First cycle of a request
   assign access    = valid & ~ready;

   // Byte lanes written under strobe, old word read out
   always_ff @(posedge clk) begin
      if (access) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
         rdata <= mem[word_addr];
      end
   end

   // Ready pulses once per request
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= access;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
   parameter int UART_DIV_RESET = 16
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        valid,
   input  wire  [soc_pkg::ADDR_W-1:0] addr,
   input  wire  [soc_pkg::DATA_W-1:0] wdata,
   input  wire  [soc_pkg::STRB_W-1:0] wstrb,
   output logic                       ready,
   output logic [soc_pkg::DATA_W-1:0] rdata,
   output logic                       ser_tx
);
   import soc_pkg::*;

   logic [1:0]  reg_sel;
   logic        is_write;
   logic        data_wr;
   logic        accept;
   logic        busy;
   logic [15:0] div;
   logic [15:0] baud_cnt;
   logic [3:0]  bits_left;
   // Stop, data, start; shifted out from bit 0
   logic [9:0]  tx_shift;

   assign reg_sel  = addr[3:2];
   assign is_write = |wstrb;
   assign data_wr  = valid & is_write & (reg_sel == UART_REG_DATA);
   assign busy     = (bits_left != 4'd0);
   // Data writes wait for the line to go idle
   assign accept   = valid & ~ready & ~(data_wr & busy);
   assign ser_tx   = tx_shift[0];

   //////////////////////////////////////////////////////////////////////
   // Bus side
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
         div   <= 16'(UART_DIV_RESET);
      end else begin
         ready <= accept;
         // Divider, low two byte lanes
         if (accept && is_write && (reg_sel == UART_REG_DIV)) begin
            if (wstrb[0]) div[7:0]  <= wdata[7:0];
            if (wstrb[1]) div[15:8] <= wdata[15:8];
         end
      end
   end

   // Read mux, data register reads as zero
   always_ff @(posedge clk) begin
      if (accept) begin
         case (reg_sel)
            UART_REG_DIV:  rdata <= {{(DATA_W-16){1'b0}}, div};
            UART_REG_STAT: rdata <= {{(DATA_W-1){1'b0}}, busy};
            default:       rdata <= '0;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Serial side, 8N1
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_shift  <= '1;
         baud_cnt  <= '0;
         bits_left <= '0;
      end else if (accept && data_wr) begin
         tx_shift  <= {1'b1, wdata[7:0], 1'b0};
         baud_cnt  <= div - 16'd1;
         bits_left <= 4'd10;
      end else if (busy) begin
         // Each bit held for div cycles
         if (baud_cnt == 16'd0) begin
            tx_shift  <= {1'b1, tx_shift[9:1]};
            baud_cnt  <= div - 16'd1;
            bits_left <= bits_left - 4'd1;
         end else begin
            baud_cnt <= baud_cnt - 16'd1;
         end
      end
   end

   // Zero divider would stretch a bit to 64K cycles
   div_nonzero: assert property (
      @(posedge clk) disable iff (reset)
      busy |-> (div != 16'd0)
   );

endmodule

`default_nettype wire
